// ==== decode_dispatch.f ====
+incdir+verif
hw/dispatch_pkg.sv
hw/operand_bypass.sv
hw/instr_decode.sv
hw/dispatch_regs.sv
hw/decode_dispatch.sv
verif/decode_dispatch_checker.sv
verif/tb_decode_dispatch.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_decode_dispatch \
  -f decode_dispatch.f

status=0
./obj_dir/Vtb_decode_dispatch > sim.log 2>&1 || status=$?
cat sim.log

# An assertion stops the simulator before the testbench summary
if [ "$status" -ne 0 ]; then
  echo "Simulation aborted with status $status" >> sim.log
  echo "CHECKS FAILED" >> sim.log
fi

if grep -q "CHECKS FAILED" sim.log; then
  echo "Simulation failed, see sim.log"
  exit 1
fi
echo "Simulation passed"

// ==== verif/decode_model.svh ====
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

function automatic data_t sext12(input logic [11:0] v);
  sext12 = {{20{v[11]}}, v};
endfunction

// Second operand of an OP-IMM instruction
function automatic data_t op_imm_value(input instr_t w);
  case (w[14:12])
    F3_SLTU:            op_imm_value = {20'd0, w[31:20]};
    F3_SLL, F3_SRL_SRA: op_imm_value = {27'd0, w[24:20]};
    default:            op_imm_value = sext12(w[31:20]);
  endcase
endfunction

function automatic rs_op_t alu_op(input instr_t w, input logic reg_form);
  logic alt;
  alt = (w[31:25] == F7_ALT);
  case (w[14:12])
    F3_ADD_SUB: alu_op = (reg_form && alt) ? RS_SUB : RS_ADD;
    F3_SLL:     alu_op = RS_SLL;
    F3_SLT:     alu_op = RS_SLT;
    F3_SLTU:    alu_op = RS_SLTU;
    F3_XOR:     alu_op = RS_XOR;
    F3_SRL_SRA: alu_op = alt ? RS_SRA : RS_SRL;
    F3_OR:      alu_op = RS_OR;
    default:    alu_op = RS_AND;
  endcase
endfunction

function automatic rs_op_t branch_op(input logic [2:0] f3);
  case (f3)
    F3_BNE:  branch_op = RS_BNE;
    F3_BLT:  branch_op = RS_BLT;
    F3_BGE:  branch_op = RS_BGE;
    F3_BLTU: branch_op = RS_BLTU;
    F3_BGEU: branch_op = RS_BGEU;
    default: branch_op = RS_BEQ;
  endcase
endfunction

task automatic clear_expected();
  exp_stall_reset   = 1'b0;
  exp_new_pc        = 32'd0;
  exp_stall_rob_idx = '0;
  exp_rf_en         = 1'b0;
  exp_rs_en         = 1'b0;
  exp_rs_op         = RS_ADD;
  exp_rs_vj         = 32'd0;
  exp_rs_qj_en      = 1'b0;
  exp_rs_qj         = '0;
  exp_rs_vk         = 32'd0;
  exp_rs_qk_en      = 1'b0;
  exp_rs_qk         = '0;
  exp_rs_rob_idx    = '0;
  exp_rob_en        = 1'b0;
  exp_rob_ready     = 1'b0;
  exp_rob_op        = ROB_REG;
  exp_rob_dest      = 5'd0;
  exp_rob_val       = 32'd0;
  exp_rob_jump      = 1'b0;
  exp_rob_pc        = 32'd0;
  exp_rob_alt_pc    = 32'd0;
endtask

// Expected register state after the clock edge that samples the current inputs
task automatic model_clock();
  logic [6:0] opc;
  logic       is_alu;
  logic       is_br;
  logic       ready_result; // LUI, AUIPC, JAL, JALR
  logic       rd_nz;
  logic       p1;
  logic       p2;
  data_t      v1;
  data_t      v2;
  addr_t      seq;
  addr_t      b_tgt;
  opc          = if_instr[6:0];
  is_alu       = (opc == OPC_R) || (opc == OPC_I);
  is_br        = (opc == OPC_B);
  ready_result = (opc == OPC_LUI) || (opc == OPC_AUIPC) || (opc == OPC_JAL) ||
                 (opc == OPC_JALR);
  rd_nz        = (if_instr[11:7] != 5'd0);
  p1  = rs1_busy && !(cdb_en && cdb_rob_idx == rs1_dep);
  p2  = rs2_busy && !(cdb_en && cdb_rob_idx == rs2_dep);
  v1  = rs1_busy ? (p1 ? 32'd0 : cdb_val) : rs1_val;
  v2  = rs2_busy ? (p2 ? 32'd0 : cdb_val) : rs2_val;
  seq = if_pc + 32'd4;
  b_tgt = if_pc + {{19{if_instr[31]}}, if_instr[31], if_instr[7], if_instr[30:25],
                   if_instr[11:8], 1'b0};

  exp_rob_idx = rob_idx_nxt;
  if (rst || roll_back) begin
    clear_expected();
  end else if (!if_in_en || !(is_alu || is_br || ready_result)) begin
    exp_stall_reset = 1'b0;
    exp_rf_en       = 1'b0;
    exp_rs_en       = 1'b0;
    exp_rob_en      = 1'b0;
  end else begin
    exp_rs_en       = is_alu || is_br;
    exp_rf_en       = (is_alu || ready_result) && rd_nz;
    exp_rob_en      = !ready_result || rd_nz;
    exp_rob_ready   = ready_result;
    exp_rob_op      = is_br ? ROB_BR : ROB_REG;
    exp_rob_dest    = if_instr[11:7];
    exp_rob_pc      = if_pc;
    exp_rob_jump    = is_br && jump;
    exp_stall_reset = 1'b0;
    case (opc)
      OPC_B: begin
        exp_stall_reset = 1'b1;
        exp_new_pc      = jump ? b_tgt : seq;
        exp_rob_val     = seq;
        exp_rob_alt_pc  = jump ? seq : b_tgt;
      end
      OPC_JAL: begin
        exp_stall_reset = 1'b1;
        exp_new_pc  = if_pc + {{11{if_instr[31]}}, if_instr[31], if_instr[19:12],
                               if_instr[20], if_instr[30:21], 1'b0};
        exp_rob_val = seq;
      end
      OPC_JALR: begin
        exp_rob_val = seq;
        if (p1) begin
          exp_stall_rob_idx = rs1_dep;
        end else begin
          exp_stall_reset = 1'b1;
          exp_new_pc      = (v1 + sext12(if_instr[31:20])) & ~32'd1;
        end
      end
      OPC_LUI:   exp_rob_val = {if_instr[31:12], 12'd0};
      OPC_AUIPC: exp_rob_val = if_pc + {if_instr[31:12], 12'd0};
      default: ;
    endcase
    if (is_alu || is_br) begin
      exp_rs_op      = is_br ? branch_op(if_instr[14:12]) : alu_op(if_instr, opc == OPC_R);
      exp_rs_vj      = v1;
      exp_rs_qj_en   = p1;
      exp_rs_qj      = rs1_dep;
      exp_rs_vk      = (opc == OPC_I) ? op_imm_value(if_instr) : v2;
      exp_rs_qk_en   = (opc == OPC_I) ? 1'b0 : p2;
      exp_rs_qk      = rs2_dep;
      exp_rs_rob_idx = rob_idx_nxt;
    end
  end
endtask

`endif

// ==== verif/tb_decode_dispatch.sv ====
`timescale 1ns/1ps

module tb_decode_dispatch;
  import dispatch_pkg::*;

  localparam int MODE_ALU    = 0;
  localparam int MODE_BRANCH = 1;
  localparam int MODE_UPPER  = 2;
  localparam int MODE_JALR   = 3;
  localparam int MODE_MIXED  = 4;

  logic     clk;
  logic     rst;
  logic     roll_back;
  logic     if_in_en;
  addr_t    if_pc;
  instr_t   if_instr;
  logic     jump;
  logic     rs1_busy;
  rob_idx_t rs1_dep;
  data_t    rs1_val;
  logic     rs2_busy;
  rob_idx_t rs2_dep;
  data_t    rs2_val;
  logic     cdb_en;
  rob_idx_t cdb_rob_idx;
  data_t    cdb_val;
  rob_idx_t rob_idx_nxt;

  logic     stall_reset;
  addr_t    new_pc;
  rob_idx_t stall_rob_idx;
  logic     rf_en;
  reg_idx_t rf_dest;
  rob_idx_t rf_rob_idx;
  logic     rs_en;
  rs_op_t   rs_op_out;
  data_t    rs_vj;
  logic     rs_qj_en;
  rob_idx_t rs_qj;
  data_t    rs_vk;
  logic     rs_qk_en;
  rob_idx_t rs_qk;
  rob_idx_t rs_rob_idx;
  logic     rob_en;
  rob_idx_t rob_idx;
  logic     rob_ready;
  rob_op_t  rob_op;
  reg_idx_t rob_dest;
  data_t    rob_val;
  logic     rob_jump;
  addr_t    rob_pc;
  addr_t    rob_alt_pc;

  // Model state
  logic     exp_stall_reset;
  addr_t    exp_new_pc;
  rob_idx_t exp_stall_rob_idx;
  logic     exp_rf_en;
  logic     exp_rs_en;
  rs_op_t   exp_rs_op;
  data_t    exp_rs_vj;
  logic     exp_rs_qj_en;
  rob_idx_t exp_rs_qj;
  data_t    exp_rs_vk;
  logic     exp_rs_qk_en;
  rob_idx_t exp_rs_qk;
  rob_idx_t exp_rs_rob_idx;
  logic     exp_rob_en;
  rob_idx_t exp_rob_idx;
  logic     exp_rob_ready;
  rob_op_t  exp_rob_op;
  reg_idx_t exp_rob_dest;
  data_t    exp_rob_val;
  logic     exp_rob_jump;
  addr_t    exp_rob_pc;
  addr_t    exp_rob_alt_pc;

  int       checks;
  int       errors;
  int       tests;
  logic     timed_out;

  `include "decode_model.svh"

  decode_dispatch u_decode_dispatch (.*);

  always #10 clk = ~clk;

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("ERROR %0d ns: %s is %h, expected %h", $time, name, got, want);
    end
  endtask

  task automatic compare_outputs();
    check_val("stall_reset", 32'(stall_reset), 32'(exp_stall_reset));
    check_val("new_pc", new_pc, exp_new_pc);
    check_val("stall_rob_idx", 32'(stall_rob_idx), 32'(exp_stall_rob_idx));
    check_val("rf_en", 32'(rf_en), 32'(exp_rf_en));
    check_val("rf_dest", 32'(rf_dest), 32'(exp_rob_dest));
    check_val("rf_rob_idx", 32'(rf_rob_idx), 32'(exp_rob_idx));
    check_val("rs_en", 32'(rs_en), 32'(exp_rs_en));
    check_val("rs_op_out", 32'(rs_op_out), 32'(exp_rs_op));
    check_val("rs_vj", rs_vj, exp_rs_vj);
    check_val("rs_qj_en", 32'(rs_qj_en), 32'(exp_rs_qj_en));
    check_val("rs_qj", 32'(rs_qj), 32'(exp_rs_qj));
    check_val("rs_vk", rs_vk, exp_rs_vk);
    check_val("rs_qk_en", 32'(rs_qk_en), 32'(exp_rs_qk_en));
    check_val("rs_qk", 32'(rs_qk), 32'(exp_rs_qk));
    check_val("rs_rob_idx", 32'(rs_rob_idx), 32'(exp_rs_rob_idx));
    check_val("rob_en", 32'(rob_en), 32'(exp_rob_en));
    check_val("rob_idx", 32'(rob_idx), 32'(exp_rob_idx));
    check_val("rob_ready", 32'(rob_ready), 32'(exp_rob_ready));
    check_val("rob_op", 32'(rob_op), 32'(exp_rob_op));
    check_val("rob_dest", 32'(rob_dest), 32'(exp_rob_dest));
    check_val("rob_val", rob_val, exp_rob_val);
    check_val("rob_jump", 32'(rob_jump), 32'(exp_rob_jump));
    check_val("rob_pc", rob_pc, exp_rob_pc);
    check_val("rob_alt_pc", rob_alt_pc, exp_rob_alt_pc);
  endtask

  // One clock, outputs checked 1 ns after the edge
  task automatic step();
    @(posedge clk);
    model_clock();
    #1;
    compare_outputs();
  endtask

  function automatic instr_t make_instr(input instr_class_t c);
    logic [31:0] r;
    logic [2:0]  f3;
    logic [6:0]  f7;
    instr_t      w;
    r  = $urandom();
    f3 = r[14:12];
    f7 = (r[30] && (f3 == F3_SRL_SRA || (c == CLS_ALU_R && f3 == F3_ADD_SUB))) ?
         F7_ALT : F7_BASE;
    case (c)
      CLS_ALU_R: w = {f7, r[24:15], f3, r[11:7], OPC_R};
      CLS_ALU_I: w = (f3 == F3_SLL || f3 == F3_SRL_SRA) ?
                     {f7, r[24:15], f3, r[11:7], OPC_I} : {r[31:15], f3, r[11:7], OPC_I};
      CLS_BRANCH: begin
        if (f3[2:1] == 2'b01)
          f3[2] = 1'b1; // 010 and 011 are not branches
        w = {r[31:15], f3, r[11:7], OPC_B};
      end
      CLS_LUI:   w = {r[31:7], OPC_LUI};
      CLS_AUIPC: w = {r[31:7], OPC_AUIPC};
      CLS_JAL:   w = {r[31:7], OPC_JAL};
      CLS_JALR:  w = {r[31:15], 3'b000, r[11:7], OPC_JALR};
      default:   w = {r[31:7], 7'b0000000}; // Opcode outside the kept set
    endcase
    make_instr = w;
  endfunction

  task automatic drive_operands();
    logic [31:0] r;
    logic [31:0] pc;
    r  = $urandom();
    pc = $urandom();
    rs1_busy    = r[0];
    rs2_busy    = r[1];
    cdb_en      = r[2];
    jump        = r[3];
    rs1_dep     = r[7:4];
    rs2_dep     = r[11:8];
    cdb_rob_idx = r[15:12];
    if (r[16])
      cdb_rob_idx = r[17] ? rs1_dep : rs2_dep; // Aim the broadcast at a source tag
    rob_idx_nxt = r[23:20];
    rs1_val     = $urandom();
    rs2_val     = $urandom();
    cdb_val     = $urandom();
    if_pc       = {pc[31:2], 2'b00};
  endtask

  task automatic drive_instr(input instr_class_t c);
    if_instr  = make_instr(c);
    if_in_en  = 1'b1;
    roll_back = 1'b0;
    drive_operands();
  endtask

  task automatic report_test(input string name, input int err0);
    tests++;
    $display("test %s: %s, %0d errors", name, (errors == err0) ? "pass" : "fail",
             errors - err0);
  endtask

  task automatic reset_test();
    int err0;
    int n;
    err0 = errors;
    repeat (5) step();
    rst      = 1'b0;
    if_in_en = 1'b0;
    repeat (3) step();
    drive_instr(CLS_ALU_R);
    n = 0;
    while (!rob_en && n < 8) begin
      step();
      if_in_en = 1'b0;
      n++;
    end
    if (!rob_en) begin
      $display("Timeout: rob_en did not rise within %0d cycles of the first instruction", n);
      timed_out = 1'b1;
    end
    report_test("reset_idle", err0);
  endtask

  task automatic run_stream(input string name, input int cycles, input int mode);
    int           err0;
    int           i;
    logic [31:0]  r;
    instr_class_t c;
    err0 = errors;
    for (i = 0; i < cycles; i++) begin
      r = $urandom();
      case (mode)
        MODE_ALU:    c = r[0] ? CLS_ALU_R : CLS_ALU_I;
        MODE_BRANCH: c = CLS_BRANCH;
        MODE_UPPER:  c = (r[1:0] == 2'd0) ? CLS_LUI : (r[1:0] == 2'd1) ? CLS_AUIPC : CLS_JAL;
        MODE_JALR:   c = CLS_JALR;
        default:     c = instr_class_t'(r[2:0]);
      endcase
      drive_instr(c);
      if ((mode == MODE_UPPER || mode == MODE_JALR) && r[5:4] == 2'b00)
        if_instr[11:7] = 5'd0;
      if (mode == MODE_MIXED) begin
        roll_back = (r[8:6] == 3'd0);
        if_in_en  = (r[11:9] != 3'd0);
      end
      step();
    end
    if_in_en  = 1'b0;
    roll_back = 1'b0;
    report_test(name, err0);
  endtask

  initial begin
    void'($urandom(32'hd38e9e5d));
    checks    = 0;
    errors    = 0;
    tests     = 0;
    timed_out = 1'b0;
    clk       = 1'b0;
    rst       = 1'b1;
    roll_back = 1'b0;
    if_in_en  = 1'b0;
    if_instr  = 32'd0;
    drive_operands();
    reset_test();
    if (!timed_out) begin
      run_stream("alu", 300, MODE_ALU);
      run_stream("branch", 150, MODE_BRANCH);
      run_stream("lui_auipc_jal", 150, MODE_UPPER);
      run_stream("jalr", 150, MODE_JALR);
      run_stream("flush_idle", 400, MODE_MIXED);
    end
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== verif/decode_dispatch_checker.sv ====
`timescale 1ns/1ps

module decode_dispatch_checker (
  input logic                   clk,
  input logic                   rst,
  input logic                   roll_back,
  input logic                   stall_reset,
  input logic                   rf_en,
  input dispatch_pkg::reg_idx_t rf_dest,
  input logic                   rs_en,
  input logic                   rob_en,
  input dispatch_pkg::rob_op_t  rob_op
);
  import dispatch_pkg::*;

  // Only branches redirect from the RS side
  redirect_only_branch: assert property (
    @(posedge clk) (rs_en && rob_op != ROB_BR) |-> !stall_reset)
    else $error("stall_reset high with a non-branch RS dispatch");

  strobes_low_after_flush: assert property (
    @(posedge clk) (rst || roll_back) |=> !(stall_reset || rf_en || rs_en || rob_en))
    else $error("strobe high in the cycle after rst or roll_back");

  no_x0_rename: assert property (@(posedge clk) rf_en |-> (rf_dest != 5'd0))
    else $error("rf_en raised for x0");

endmodule

bind dispatch_regs decode_dispatch_checker u_decode_dispatch_checker (
  .clk(clk), .rst(rst), .roll_back(roll_back), .stall_reset(stall_reset),
  .rf_en(rf_en), .rf_dest(rf_dest), .rs_en(rs_en), .rob_en(rob_en), .rob_op(rob_op)
);

// ==== hw/decode_dispatch.sv ====
`timescale 1ns/1ps

module decode_dispatch (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   roll_back,
  input  logic                   if_in_en,
  input  dispatch_pkg::addr_t    if_pc,
  input  dispatch_pkg::instr_t   if_instr,
  input  logic                   jump,
  input  logic                   rs1_busy,
  input  dispatch_pkg::rob_idx_t rs1_dep,
  input  dispatch_pkg::data_t    rs1_val,
  input  logic                   rs2_busy,
  input  dispatch_pkg::rob_idx_t rs2_dep,
  input  dispatch_pkg::data_t    rs2_val,
  input  logic                   cdb_en,
  input  dispatch_pkg::rob_idx_t cdb_rob_idx,
  input  dispatch_pkg::data_t    cdb_val,
  input  dispatch_pkg::rob_idx_t rob_idx_nxt,
  output logic                   stall_reset,
  output dispatch_pkg::addr_t    new_pc,
  output dispatch_pkg::rob_idx_t stall_rob_idx,
  output logic                   rf_en,
  output dispatch_pkg::reg_idx_t rf_dest,
  output dispatch_pkg::rob_idx_t rf_rob_idx,
  output logic                   rs_en,
  output dispatch_pkg::rs_op_t   rs_op_out,
  output dispatch_pkg::data_t    rs_vj,
  output logic                   rs_qj_en,
  output dispatch_pkg::rob_idx_t rs_qj,
  output dispatch_pkg::data_t    rs_vk,
  output logic                   rs_qk_en,
  output dispatch_pkg::rob_idx_t rs_qk,
  output dispatch_pkg::rob_idx_t rs_rob_idx,
  output logic                   rob_en,
  output dispatch_pkg::rob_idx_t rob_idx,
  output logic                   rob_ready,
  output dispatch_pkg::rob_op_t  rob_op,
  output dispatch_pkg::reg_idx_t rob_dest,
  output dispatch_pkg::data_t    rob_val,
  output logic                   rob_jump,
  output dispatch_pkg::addr_t    rob_pc,
  output dispatch_pkg::addr_t    rob_alt_pc
);
  import dispatch_pkg::*;

  logic         op1_pend;
  logic         op2_pend;
  data_t        op1_val;
  data_t        op2_val;
  instr_class_t cls;
  rs_op_t       rs_op;
  reg_idx_t     rd;
  data_t        imm;
  logic         vk_sel_imm;
  addr_t        pc_plus4;
  addr_t        br_target;
  addr_t        jal_target;
  addr_t        jalr_target;
  data_t        result_val;

  operand_bypass u_operand_bypass (
    .rs1_busy(rs1_busy), .rs1_dep(rs1_dep), .rs1_val(rs1_val),
    .rs2_busy(rs2_busy), .rs2_dep(rs2_dep), .rs2_val(rs2_val),
    .cdb_en(cdb_en), .cdb_rob_idx(cdb_rob_idx), .cdb_val(cdb_val),
    .op1_pend(op1_pend), .op1_val(op1_val),
    .op2_pend(op2_pend), .op2_val(op2_val)
  );

  instr_decode u_instr_decode (
    .if_instr(if_instr), .if_pc(if_pc), .op1_val(op1_val),
    .cls(cls), .rs_op(rs_op), .rd(rd), .imm(imm), .vk_sel_imm(vk_sel_imm),
    .pc_plus4(pc_plus4), .br_target(br_target), .jal_target(jal_target),
    .jalr_target(jalr_target), .result_val(result_val)
  );

  dispatch_regs u_dispatch_regs (
    .clk(clk), .rst(rst), .roll_back(roll_back), .if_in_en(if_in_en), .jump(jump),
    .if_pc(if_pc), .cls(cls), .rs_op(rs_op), .rd(rd), .imm(imm),
    .vk_sel_imm(vk_sel_imm), .pc_plus4(pc_plus4), .br_target(br_target),
    .jal_target(jal_target), .jalr_target(jalr_target), .result_val(result_val),
    .op1_pend(op1_pend), .op2_pend(op2_pend), .op1_val(op1_val), .op2_val(op2_val),
    .rs1_dep(rs1_dep), .rs2_dep(rs2_dep), .rob_idx_nxt(rob_idx_nxt),
    .stall_reset(stall_reset), .new_pc(new_pc), .stall_rob_idx(stall_rob_idx),
    .rf_en(rf_en), .rf_dest(rf_dest), .rf_rob_idx(rf_rob_idx),
    .rs_en(rs_en), .rs_op_out(rs_op_out), .rs_vj(rs_vj), .rs_qj_en(rs_qj_en),
    .rs_qj(rs_qj), .rs_vk(rs_vk), .rs_qk_en(rs_qk_en), .rs_qk(rs_qk),
    .rs_rob_idx(rs_rob_idx), .rob_en(rob_en), .rob_idx(rob_idx),
    .rob_ready(rob_ready), .rob_op(rob_op), .rob_dest(rob_dest), .rob_val(rob_val),
    .rob_jump(rob_jump), .rob_pc(rob_pc), .rob_alt_pc(rob_alt_pc)
  );

endmodule

// ==== hw/dispatch_regs.sv ====
`timescale 1ns/1ps

module dispatch_regs (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       roll_back,
  input  logic                       if_in_en,
  input  logic                       jump,
  input  dispatch_pkg::addr_t        if_pc,
  input  dispatch_pkg::instr_class_t cls,
  input  dispatch_pkg::rs_op_t       rs_op,
  input  dispatch_pkg::reg_idx_t     rd,
  input  dispatch_pkg::data_t        imm,
  input  logic                       vk_sel_imm,
  input  dispatch_pkg::addr_t        pc_plus4,
  input  dispatch_pkg::addr_t        br_target,
  input  dispatch_pkg::addr_t        jal_target,
  input  dispatch_pkg::addr_t        jalr_target,
  input  dispatch_pkg::data_t        result_val,
  input  logic                       op1_pend,
  input  logic                       op2_pend,
  input  dispatch_pkg::data_t        op1_val,
  input  dispatch_pkg::data_t        op2_val,
  input  dispatch_pkg::rob_idx_t     rs1_dep,
  input  dispatch_pkg::rob_idx_t     rs2_dep,
  input  dispatch_pkg::rob_idx_t     rob_idx_nxt,
  output logic                       stall_reset,
  output dispatch_pkg::addr_t        new_pc,
  output dispatch_pkg::rob_idx_t     stall_rob_idx,
  output logic                       rf_en,
  output dispatch_pkg::reg_idx_t     rf_dest,
  output dispatch_pkg::rob_idx_t     rf_rob_idx,
  output logic                       rs_en,
  output dispatch_pkg::rs_op_t       rs_op_out,
  output dispatch_pkg::data_t        rs_vj,
  output logic                       rs_qj_en,
  output dispatch_pkg::rob_idx_t     rs_qj,
  output dispatch_pkg::data_t        rs_vk,
  output logic                       rs_qk_en,
  output dispatch_pkg::rob_idx_t     rs_qk,
  output dispatch_pkg::rob_idx_t     rs_rob_idx,
  output logic                       rob_en,
  output dispatch_pkg::rob_idx_t     rob_idx,
  output logic                       rob_ready,
  output dispatch_pkg::rob_op_t      rob_op,
  output dispatch_pkg::reg_idx_t     rob_dest,
  output dispatch_pkg::data_t        rob_val,
  output logic                       rob_jump,
  output dispatch_pkg::addr_t        rob_pc,
  output dispatch_pkg::addr_t        rob_alt_pc
);
  import dispatch_pkg::*;

  logic  is_rs;
  logic  is_branch;
  logic  has_result; // LUI, AUIPC, JAL, JALR
  logic  rd_nz;
  logic  redirect;
  logic  jalr_wait;
  addr_t redirect_pc;

  assign is_branch  = (cls == CLS_BRANCH);
  assign is_rs      = (cls == CLS_ALU_R) || (cls == CLS_ALU_I) || is_branch;
  assign has_result = (cls == CLS_LUI) || (cls == CLS_AUIPC) ||
                      (cls == CLS_JAL) || (cls == CLS_JALR);
  assign rd_nz      = (rd != 5'd0);

  always_comb begin
    redirect    = 1'b0;
    jalr_wait   = 1'b0;
    redirect_pc = pc_plus4;
    case (cls)
      CLS_BRANCH: begin
        redirect    = 1'b1;
        redirect_pc = jump ? br_target : pc_plus4;
      end
      CLS_JAL: begin
        redirect    = 1'b1;
        redirect_pc = jal_target;
      end
      CLS_JALR: begin
        if (op1_pend) begin
          jalr_wait = 1'b1; // Base not known yet
        end else begin
          redirect    = 1'b1;
          redirect_pc = jalr_target;
        end
      end
      default: ;
    endcase
  end

  // Tag follows the ROB every cycle
  always_ff @(posedge clk) begin
    rob_idx <= rob_idx_nxt;
  end

  always_ff @(posedge clk) begin
    if (rst || roll_back) begin
      stall_reset   <= 1'b0;
      new_pc        <= 32'd0;
      stall_rob_idx <= '0;
      rf_en         <= 1'b0;
      rs_en         <= 1'b0;
      rs_op_out     <= RS_ADD;
      rs_vj         <= 32'd0;
      rs_qj_en      <= 1'b0;
      rs_qj         <= '0;
      rs_vk         <= 32'd0;
      rs_qk_en      <= 1'b0;
      rs_qk         <= '0;
      rs_rob_idx    <= '0;
      rob_en        <= 1'b0;
      rob_ready     <= 1'b0;
      rob_op        <= ROB_REG;
      rob_dest      <= 5'd0;
      rob_val       <= 32'd0;
      rob_jump      <= 1'b0;
      rob_pc        <= 32'd0;
      rob_alt_pc    <= 32'd0;
    end else if (if_in_en && cls != CLS_NONE) begin
      stall_reset <= redirect;
      if (redirect)
        new_pc <= redirect_pc;
      if (jalr_wait)
        stall_rob_idx <= rs1_dep;

      rf_en  <= (is_rs && !is_branch || has_result) && rd_nz;
      rs_en  <= is_rs;
      rob_en <= !has_result || rd_nz; // x0 writes need no ROB slot

      rob_ready <= has_result;
      rob_op    <= is_branch ? ROB_BR : ROB_REG;
      rob_dest  <= rd;
      rob_pc    <= if_pc;
      rob_jump  <= is_branch && jump;
      if (has_result)
        rob_val <= result_val;
      if (is_branch) begin
        rob_val    <= pc_plus4;
        rob_alt_pc <= jump ? pc_plus4 : br_target; // Path not predicted
      end

      if (is_rs) begin
        rs_op_out  <= rs_op;
        rs_vj      <= op1_val;
        rs_qj_en   <= op1_pend;
        rs_qj      <= rs1_dep;
        rs_vk      <= vk_sel_imm ? imm : op2_val;
        rs_qk_en   <= op2_pend && !vk_sel_imm;
        rs_qk      <= rs2_dep;
        rs_rob_idx <= rob_idx_nxt;
      end
    end else begin
      stall_reset <= 1'b0;
      rf_en       <= 1'b0;
      rs_en       <= 1'b0;
      rob_en      <= 1'b0;
    end
  end

  assign rf_dest    = rob_dest;
  assign rf_rob_idx = rob_idx;

endmodule

// ==== hw/instr_decode.sv ====
`timescale 1ns/1ps

module instr_decode (
  input  dispatch_pkg::instr_t       if_instr,
  input  dispatch_pkg::addr_t        if_pc,
  input  dispatch_pkg::data_t        op1_val,
  output dispatch_pkg::instr_class_t cls,
  output dispatch_pkg::rs_op_t       rs_op,
  output dispatch_pkg::reg_idx_t     rd,
  output dispatch_pkg::data_t        imm,
  output logic                       vk_sel_imm,
  output dispatch_pkg::addr_t        pc_plus4,
  output dispatch_pkg::addr_t        br_target,
  output dispatch_pkg::addr_t        jal_target,
  output dispatch_pkg::addr_t        jalr_target,
  output dispatch_pkg::data_t        result_val
);
  import dispatch_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  data_t      imm_i;
  data_t      imm_b;
  data_t      imm_j;
  data_t      imm_u;
  addr_t      jalr_sum;

  assign opcode = if_instr[6:0];
  assign funct3 = if_instr[14:12];
  assign funct7 = if_instr[31:25];
  assign rd     = if_instr[11:7];

  assign imm_i = {{20{if_instr[31]}}, if_instr[31:20]};
  assign imm_b = {{19{if_instr[31]}}, if_instr[31], if_instr[7], if_instr[30:25],
                  if_instr[11:8], 1'b0};
  assign imm_j = {{11{if_instr[31]}}, if_instr[31], if_instr[19:12], if_instr[20],
                  if_instr[30:21], 1'b0};
  assign imm_u = {if_instr[31:12], 12'd0};

  always_comb begin
    case (opcode)
      OPC_R:     cls = CLS_ALU_R;
      OPC_I:     cls = CLS_ALU_I;
      OPC_B:     cls = CLS_BRANCH;
      OPC_LUI:   cls = CLS_LUI;
      OPC_AUIPC: cls = CLS_AUIPC;
      OPC_JAL:   cls = CLS_JAL;
      OPC_JALR:  cls = CLS_JALR;
      default:   cls = CLS_NONE; // Dispatched as a bubble
    endcase
  end

  always_comb begin
    rs_op = RS_ADD;
    if (cls == CLS_BRANCH) begin
      case (funct3)
        F3_BEQ:  rs_op = RS_BEQ;
        F3_BNE:  rs_op = RS_BNE;
        F3_BLT:  rs_op = RS_BLT;
        F3_BGE:  rs_op = RS_BGE;
        F3_BLTU: rs_op = RS_BLTU;
        F3_BGEU: rs_op = RS_BGEU;
        default: rs_op = RS_BEQ;
      endcase
    end else begin
      case (funct3)
        F3_ADD_SUB: rs_op = (cls == CLS_ALU_R && funct7 == F7_ALT) ? RS_SUB : RS_ADD;
        F3_SLL:     rs_op = RS_SLL;
        F3_SLT:     rs_op = RS_SLT;
        F3_SLTU:    rs_op = RS_SLTU;
        F3_XOR:     rs_op = RS_XOR;
        F3_SRL_SRA: rs_op = (funct7 == F7_ALT) ? RS_SRA : RS_SRL; // SRAI shares funct7
        F3_OR:      rs_op = RS_OR;
        default:    rs_op = RS_AND;
      endcase
    end
  end

  // Second ALU operand for I-type
  always_comb begin
    imm = imm_i;
    if (cls == CLS_ALU_I) begin
      case (funct3)
        F3_SLTU:           imm = {20'd0, if_instr[31:20]};
        F3_SLL, F3_SRL_SRA: imm = {27'd0, if_instr[24:20]}; // shamt only
        default:           imm = imm_i;
      endcase
    end
  end

  assign vk_sel_imm = (cls == CLS_ALU_I);

  assign pc_plus4    = if_pc + 32'd4;
  assign br_target   = if_pc + imm_b;
  assign jal_target  = if_pc + imm_j;
  assign jalr_sum    = op1_val + imm_i;
  assign jalr_target = {jalr_sum[31:1], 1'b0};

  always_comb begin
    case (cls)
      CLS_LUI:           result_val = imm_u;
      CLS_AUIPC:         result_val = if_pc + imm_u;
      CLS_JAL, CLS_JALR: result_val = pc_plus4; // Link address
      default:           result_val = 32'd0;
    endcase
  end

endmodule

// ==== hw/operand_bypass.sv ====
`timescale 1ns/1ps

module operand_bypass (
  input  logic                   rs1_busy,
  input  dispatch_pkg::rob_idx_t rs1_dep,
  input  dispatch_pkg::data_t    rs1_val,
  input  logic                   rs2_busy,
  input  dispatch_pkg::rob_idx_t rs2_dep,
  input  dispatch_pkg::data_t    rs2_val,
  input  logic                   cdb_en,
  input  dispatch_pkg::rob_idx_t cdb_rob_idx,
  input  dispatch_pkg::data_t    cdb_val,
  output logic                   op1_pend,
  output dispatch_pkg::data_t    op1_val,
  output logic                   op2_pend,
  output dispatch_pkg::data_t    op2_val
);
  import dispatch_pkg::*;

  // Returns {pending, value} for one source operand
  function automatic logic [32:0] resolve(input logic busy, input rob_idx_t dep,
                                          input data_t val);
    logic hit;
    hit = busy && cdb_en && (dep == cdb_rob_idx);
    if (!busy)
      resolve = {1'b0, val};
    else if (hit)
      resolve = {1'b0, cdb_val}; // Result arrives this cycle
    else
      resolve = {1'b1, 32'd0};
  endfunction

  assign {op1_pend, op1_val} = resolve(rs1_busy, rs1_dep, rs1_val);
  assign {op2_pend, op2_val} = resolve(rs2_busy, rs2_dep, rs2_val);

endmodule

// ==== hw/dispatch_pkg.sv ====
package dispatch_pkg;

  localparam int ROB_IDX_W = 4;

  typedef logic [31:0]          addr_t;
  typedef logic [31:0]          data_t;
  typedef logic [31:0]          instr_t;
  typedef logic [ROB_IDX_W-1:0] rob_idx_t;
  typedef logic [4:0]           reg_idx_t;
  typedef logic [3:0]           rs_op_t;
  typedef logic [1:0]           rob_op_t;
  typedef logic [2:0]           instr_class_t;

  // RV32I major opcodes kept by this stage
  localparam logic [6:0] OPC_R     = 7'b0110011;
  localparam logic [6:0] OPC_I     = 7'b0010011;
  localparam logic [6:0] OPC_B     = 7'b1100011;
  localparam logic [6:0] OPC_LUI   = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC = 7'b0010111;
  localparam logic [6:0] OPC_JAL   = 7'b1101111;
  localparam logic [6:0] OPC_JALR  = 7'b1100111;

  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000; // SUB, SRA, SRAI

  localparam rs_op_t RS_ADD  = 4'd0;
  localparam rs_op_t RS_SUB  = 4'd1;
  localparam rs_op_t RS_SLL  = 4'd2;
  localparam rs_op_t RS_SLT  = 4'd3;
  localparam rs_op_t RS_SLTU = 4'd4;
  localparam rs_op_t RS_XOR  = 4'd5;
  localparam rs_op_t RS_SRL  = 4'd6;
  localparam rs_op_t RS_SRA  = 4'd7;
  localparam rs_op_t RS_OR   = 4'd8;
  localparam rs_op_t RS_AND  = 4'd9;
  localparam rs_op_t RS_BEQ  = 4'd10;
  localparam rs_op_t RS_BNE  = 4'd11;
  localparam rs_op_t RS_BLT  = 4'd12;
  localparam rs_op_t RS_BGE  = 4'd13;
  localparam rs_op_t RS_BLTU = 4'd14;
  localparam rs_op_t RS_BGEU = 4'd15;

  localparam rob_op_t ROB_REG = 2'd0;
  localparam rob_op_t ROB_BR  = 2'd1;

  localparam instr_class_t CLS_NONE   = 3'd0;
  localparam instr_class_t CLS_ALU_R  = 3'd1;
  localparam instr_class_t CLS_ALU_I  = 3'd2;
  localparam instr_class_t CLS_BRANCH = 3'd3;
  localparam instr_class_t CLS_LUI    = 3'd4;
  localparam instr_class_t CLS_AUIPC  = 3'd5;
  localparam instr_class_t CLS_JAL    = 3'd6;
  localparam instr_class_t CLS_JALR   = 3'd7;

endpackage
